// ==== src/gauss_pkg.sv ====
package gauss_pkg;

	typedef logic [7:0] channel_t;

	// Red sits in the high byte, blue in the low byte.
	typedef struct packed {
		channel_t r;
		channel_t g;
		channel_t b;
	} pixel_t;

	typedef logic [7:0] coeff_t;

	// Holds 121 products of 8x8 bits.
	typedef logic [23:0] acc_t;

	localparam int KERNEL_SIZE = 11;

	// Fraction bits dropped after accumulation.
	localparam int SUM_SHIFT = 4;

	// Accepting edge to out_valid.
	localparam int PIPE_LATENCY = 4;

	typedef enum logic {
		FILLING,
		RUNNING
	} fill_state_t;

	// Symmetric Gaussian weights, total 267.
	localparam coeff_t COEFF_TABLE [KERNEL_SIZE][KERNEL_SIZE] = '{
		'{8'd1, 8'd1, 8'd2, 8'd2, 8'd2, 8'd2, 8'd2, 8'd2, 8'd2, 8'd1, 8'd1},
		'{8'd1, 8'd2, 8'd2, 8'd2, 8'd2, 8'd2, 8'd2, 8'd2, 8'd2, 8'd2, 8'd1},
		'{8'd2, 8'd2, 8'd2, 8'd2, 8'd3, 8'd3, 8'd3, 8'd2, 8'd2, 8'd2, 8'd2},
		'{8'd2, 8'd2, 8'd2, 8'd3, 8'd3, 8'd3, 8'd3, 8'd3, 8'd2, 8'd2, 8'd2},
		'{8'd2, 8'd2, 8'd3, 8'd3, 8'd3, 8'd3, 8'd3, 8'd3, 8'd3, 8'd2, 8'd2},
		'{8'd2, 8'd2, 8'd3, 8'd3, 8'd3, 8'd3, 8'd3, 8'd3, 8'd3, 8'd2, 8'd2},
		'{8'd2, 8'd2, 8'd3, 8'd3, 8'd3, 8'd3, 8'd3, 8'd3, 8'd3, 8'd2, 8'd2},
		'{8'd2, 8'd2, 8'd2, 8'd3, 8'd3, 8'd3, 8'd3, 8'd3, 8'd2, 8'd2, 8'd2},
		'{8'd2, 8'd2, 8'd2, 8'd2, 8'd3, 8'd3, 8'd3, 8'd2, 8'd2, 8'd2, 8'd2},
		'{8'd1, 8'd2, 8'd2, 8'd2, 8'd2, 8'd2, 8'd2, 8'd2, 8'd2, 8'd2, 8'd1},
		'{8'd1, 8'd1, 8'd2, 8'd2, 8'd2, 8'd2, 8'd2, 8'd2, 8'd2, 8'd1, 8'd1}
	};

endpackage

// ==== src/gauss_line_buffer.sv ====
`timescale 1ns/10ps

module gauss_line_buffer #(
	parameter int LINE_WIDTH = 640
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              pix_valid,
	input  gauss_pkg::pixel_t pix_in,
	output gauss_pkg::pixel_t col_taps [gauss_pkg::KERNEL_SIZE],
	output logic              col_valid,
	output logic              win_full
);

	import gauss_pkg::*;

	// Ten stored lines plus the incoming pixel give eleven taps.
	localparam int LINE_COUNT = KERNEL_SIZE - 1;

	// Pixels that must precede the first complete window.
	localparam int WARMUP = LINE_COUNT * LINE_WIDTH + LINE_COUNT;

	localparam int COL_W = (LINE_WIDTH > 1) ? $clog2(LINE_WIDTH) : 1;
	localparam int FILL_W = $clog2(WARMUP + 1);

	logic [COL_W-1:0]  col;
	logic [FILL_W-1:0] fill_cnt;
	fill_state_t       state;

	// Old contents of every line at the current column.
	wire pixel_t line_rd [LINE_COUNT];

	// Column position within the current line.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col <= '0;
		end else if (pix_valid) begin
			if (col == COL_W'(LINE_WIDTH - 1)) begin
				col <= '0;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// Each line takes the value the line above held at this column.
	for (genvar g = 0; g < LINE_COUNT; g++) begin : g_line
		pixel_t      mem [LINE_WIDTH];
		wire pixel_t wr_data;

		if (g == 0) begin : g_head
			assign wr_data = pix_in;
		end else begin : g_tail
			assign wr_data = line_rd[g-1];
		end

		always_ff @(posedge clk) begin
			if (pix_valid) begin
				mem[col] <= wr_data;
			end
		end

		assign line_rd[g] = mem[col];
	end

	// Warm-up FSM.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= FILLING;
			fill_cnt <= '0;
		end else if (pix_valid) begin
			case (state)
				FILLING: begin
					fill_cnt <= fill_cnt + 1'b1;
					if (fill_cnt == FILL_W'(WARMUP - 1)) begin
						state <= RUNNING;
					end
				end
				RUNNING: begin
					state <= RUNNING;
				end
				default: begin
					state <= FILLING;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col_valid <= 1'b0;
			win_full  <= 1'b0;
		end else begin
			col_valid <= pix_valid;
			win_full  <= pix_valid && (state == RUNNING);
		end
	end

	// Tap 0 is the new pixel, tap r comes from r lines back.
	always_ff @(posedge clk) begin
		if (pix_valid) begin
			col_taps[0] <= pix_in;
			for (int r = 1; r < KERNEL_SIZE; r++) begin
				col_taps[r] <= line_rd[r-1];
			end
		end
	end

endmodule

// ==== src/gauss_window.sv ====
`timescale 1ns/10ps

module gauss_window (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              col_valid,
	input  logic              win_full,
	input  gauss_pkg::pixel_t col_taps [gauss_pkg::KERNEL_SIZE],
	output gauss_pkg::pixel_t window [gauss_pkg::KERNEL_SIZE][gauss_pkg::KERNEL_SIZE],
	output logic              win_valid
);

	import gauss_pkg::*;

	// One shift row per tap, column 0 holds the newest pixel.
	for (genvar r = 0; r < KERNEL_SIZE; r++) begin : g_row
		always_ff @(posedge clk) begin
			if (col_valid) begin
				window[r][0] <= col_taps[r];
				for (int c = 1; c < KERNEL_SIZE; c++) begin
					window[r][c] <= window[r][c-1];
				end
			end
		end
	end

	// Valid only for a column that completes a full window.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			win_valid <= 1'b0;
		end else begin
			win_valid <= col_valid && win_full;
		end
	end

endmodule

// ==== src/gauss_conv.sv ====
`timescale 1ns/10ps

module gauss_conv (
	input  logic                clk,
	input  logic                rst_n,
	input  gauss_pkg::pixel_t   window [gauss_pkg::KERNEL_SIZE][gauss_pkg::KERNEL_SIZE],
	input  logic                win_valid,
	output logic                out_valid,
	output gauss_pkg::channel_t out_r,
	output gauss_pkg::channel_t out_g,
	output gauss_pkg::channel_t out_b
);

	import gauss_pkg::*;

	// Channel 0 is red, 1 is green, 2 is blue.
	localparam int NUM_CHAN = 3;
	localparam acc_t CHAN_MAX = acc_t'(255);

	acc_t row_sum_d [NUM_CHAN][KERNEL_SIZE];
	acc_t row_sum_q [NUM_CHAN][KERNEL_SIZE];
	acc_t total [NUM_CHAN];
	logic stage1_valid;

	function automatic channel_t pick_chan(input pixel_t p, input int ch);
		case (ch)
			0: return p.r;
			1: return p.g;
			default: return p.b;
		endcase
	endfunction

	// Drop the fraction bits, then clamp to 8 bits.
	function automatic channel_t saturate(input acc_t sum);
		acc_t scaled;
		scaled = sum >> SUM_SHIFT;
		if (scaled > CHAN_MAX) begin
			return 8'hff;
		end
		return channel_t'(scaled);
	endfunction

	// Stage one: weighted sum along each window row.
	always_comb begin
		for (int ch = 0; ch < NUM_CHAN; ch++) begin
			for (int r = 0; r < KERNEL_SIZE; r++) begin
				row_sum_d[ch][r] = '0;
				for (int c = 0; c < KERNEL_SIZE; c++) begin
					row_sum_d[ch][r] = row_sum_d[ch][r]
						+ acc_t'(COEFF_TABLE[r][c]) * acc_t'(pick_chan(window[r][c], ch));
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		row_sum_q <= row_sum_d;
	end

	// Stage two: add the row sums.
	always_comb begin
		for (int ch = 0; ch < NUM_CHAN; ch++) begin
			total[ch] = '0;
			for (int r = 0; r < KERNEL_SIZE; r++) begin
				total[ch] = total[ch] + row_sum_q[ch][r];
			end
		end
	end

	always_ff @(posedge clk) begin
		out_r <= saturate(total[0]);
		out_g <= saturate(total[1]);
		out_b <= saturate(total[2]);
	end

	// Valid flag follows the two data stages.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage1_valid <= 1'b0;
			out_valid    <= 1'b0;
		end else begin
			stage1_valid <= win_valid;
			out_valid    <= stage1_valid;
		end
	end

endmodule

// ==== src/gauss_filter_top.sv ====
`timescale 1ns/10ps

module gauss_filter_top #(
	parameter int LINE_WIDTH = 640
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                pix_valid,
	input  gauss_pkg::pixel_t   pix_in,
	output logic                out_valid,
	output gauss_pkg::channel_t out_r,
	output gauss_pkg::channel_t out_g,
	output gauss_pkg::channel_t out_b
);

	import gauss_pkg::*;

	pixel_t col_taps [KERNEL_SIZE];
	logic   col_valid;
	logic   win_full;

	pixel_t window [KERNEL_SIZE][KERNEL_SIZE];
	logic   win_valid;

	// Vertical column of taps, one per accepted pixel.
	gauss_line_buffer #(
		.LINE_WIDTH(LINE_WIDTH)
	) line_buffer0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.pix_valid (pix_valid),
		.pix_in    (pix_in),
		.col_taps  (col_taps),
		.col_valid (col_valid),
		.win_full  (win_full)
	);

	gauss_window window0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.col_valid (col_valid),
		.win_full  (win_full),
		.col_taps  (col_taps),
		.window    (window),
		.win_valid (win_valid)
	);

	gauss_conv conv0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.window    (window),
		.win_valid (win_valid),
		.out_valid (out_valid),
		.out_r     (out_r),
		.out_g     (out_g),
		.out_b     (out_b)
	);

endmodule

// ==== sim/gauss_tb_asserts.sv ====
`timescale 1ns/10ps

module gauss_tb_asserts (
	input logic                clk,
	input logic                rst_n,
	input logic                pix_valid,
	input logic                out_valid,
	input gauss_pkg::channel_t out_r,
	input gauss_pkg::channel_t out_g,
	input gauss_pkg::channel_t out_b
);

	import gauss_pkg::*;

	int fail_count = 0;

	// No result may leave the pipeline while reset is held.
	quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else begin
			$error("out_valid high while rst_n is low");
			fail_count++;
		end

	// Every result goes back to an accepted pixel.
	output_has_source: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(pix_valid, PIPE_LATENCY))
		else begin
			$error("out_valid without an accepted pixel PIPE_LATENCY cycles before");
			fail_count++;
		end

	output_known: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !$isunknown({out_r, out_g, out_b}))
		else begin
			$error("unknown output channel while out_valid is high");
			fail_count++;
		end

endmodule

bind gauss_filter_top gauss_tb_asserts asserts0 (
	.clk       (clk),
	.rst_n     (rst_n),
	.pix_valid (pix_valid),
	.out_valid (out_valid),
	.out_r     (out_r),
	.out_g     (out_g),
	.out_b     (out_b)
);

// ==== sim/gauss_tb.sv ====
`timescale 1ns/10ps

module gauss_tb;

	import gauss_pkg::*;

	localparam int LW = 16;
	localparam int WARMUP = (KERNEL_SIZE - 1) * LW + (KERNEL_SIZE - 1);
	localparam int KERNEL_WEIGHT = 267;
	localparam int IMG_DEPTH = 1024;
	localparam int CLK_PERIOD = 20;

	// Pixels over all tests, reset and drain cycles come on top.
	localparam int TOTAL_PIXELS = (WARMUP + 1) + 2 * 12 * LW + 2 * 20 * LW + 250 + 200;
	localparam int TIMEOUT_NS = TOTAL_PIXELS * 2 * CLK_PERIOD + 20000;

	logic     clk;
	logic     rst_n;
	logic     pix_valid;
	pixel_t   pix_in;
	logic     out_valid;
	channel_t out_r;
	channel_t out_g;
	channel_t out_b;

	integer seed = 67176;
	int     cyc = 0;
	int     errors = 0;
	int     out_count = 0;
	int     n_acc = 0;
	int     tests_run = 0;
	int     tests_failing = 0;
	int     test_start = 0;
	bit     flat_check = 1'b0;
	pixel_t flat_pix;
	pixel_t img [IMG_DEPTH];
	int     exp_idx_q [$];
	int     exp_edge_q [$];

	gauss_filter_top #(
		.LINE_WIDTH(LW)
	) dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.pix_valid (pix_valid),
		.pix_in    (pix_in),
		.out_valid (out_valid),
		.out_r     (out_r),
		.out_g     (out_g),
		.out_b     (out_b)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	function automatic channel_t clamp_channel(input int v);
		return (v > 255) ? 8'd255 : channel_t'(v);
	endfunction

	// Weighted sum over the 11x11 neighbourhood of pixel n in raster order.
	function automatic pixel_t blur_ref(input int n);
		int     sum_r;
		int     sum_g;
		int     sum_b;
		pixel_t p;
		pixel_t res;
		sum_r = 0;
		sum_g = 0;
		sum_b = 0;
		for (int r = 0; r < KERNEL_SIZE; r++) begin
			for (int c = 0; c < KERNEL_SIZE; c++) begin
				p = img[n - r * LW - c];
				sum_r += int'(COEFF_TABLE[r][c]) * int'(p.r);
				sum_g += int'(COEFF_TABLE[r][c]) * int'(p.g);
				sum_b += int'(COEFF_TABLE[r][c]) * int'(p.b);
			end
		end
		res.r = clamp_channel(sum_r >> SUM_SHIFT);
		res.g = clamp_channel(sum_g >> SUM_SHIFT);
		res.b = clamp_channel(sum_b >> SUM_SHIFT);
		return res;
	endfunction

	function automatic channel_t flat_expect(input int v);
		return clamp_channel((KERNEL_WEIGHT * v) >> SUM_SHIFT);
	endfunction

	function automatic int total_errors();
		return errors + dut0.asserts0.fail_count;
	endfunction

	// Outputs are checked first, then the pixel about to be accepted is recorded.
	always @(negedge clk) begin : compare_outputs
		int     idx;
		int     acc_edge;
		pixel_t exp_pix;
		pixel_t got;
		got = {out_r, out_g, out_b};
		if (rst_n && out_valid) begin
			out_count++;
			assert (exp_idx_q.size() > 0) else begin
				$display("unexpected output at %0t ns, no pixel was waiting for a result", $time);
				errors++;
			end
			if (exp_idx_q.size() > 0) begin
				idx = exp_idx_q.pop_front();
				acc_edge = exp_edge_q.pop_front();
				exp_pix = blur_ref(idx);
				assert (cyc + 1 - acc_edge == PIPE_LATENCY) else begin
					$display("error %0t: pixel %0d came out %0d edges after acceptance",
						$time, idx, cyc + 1 - acc_edge);
					errors++;
				end
				assert (got == exp_pix) else begin
					$display("error %0t: pixel %0d got %h, expected %h", $time, idx, got, exp_pix);
					errors++;
				end
				if (flat_check) begin
					assert (got == flat_pix) else begin
						$display("error %0t: flat pixel %0d got %h, expected %h",
							$time, idx, got, flat_pix);
						errors++;
					end
				end
			end
		end
		if (rst_n && pix_valid) begin
			img[n_acc] = pix_in;
			if (n_acc >= WARMUP) begin
				exp_idx_q.push_back(n_acc);
				exp_edge_q.push_back(cyc + 1);
			end
			n_acc++;
		end
	end

	task automatic apply_reset();
		@(posedge clk);
		pix_valid <= 1'b0;
		rst_n     <= 1'b0;
		repeat (8) @(posedge clk);
		exp_idx_q.delete();
		exp_edge_q.delete();
		n_acc = 0;
		out_count = 0;
		rst_n <= 1'b1;
	endtask

	// Optional idle cycles, about one in three, before each pixel.
	task automatic drive_pixel(input pixel_t p, input bit gaps);
		while (gaps && ({$random(seed)} % 3 == 0)) begin
			@(posedge clk);
			pix_valid <= 1'b0;
		end
		@(posedge clk);
		pix_valid <= 1'b1;
		pix_in    <= p;
	endtask

	task automatic send_random(input int count, input bit gaps);
		logic [31:0] rnd;
		for (int i = 0; i < count; i++) begin
			rnd = $random(seed);
			// Red never clips, green sits near the clip level, blue mostly clips.
			drive_pixel(rnd[23:0] & 24'h0f1fff, gaps);
		end
	endtask

	task automatic send_flat(input int count, input pixel_t p);
		for (int i = 0; i < count; i++) begin
			drive_pixel(p, 1'b0);
		end
	endtask

	task automatic drain_outputs();
		int waited;
		waited = 0;
		@(posedge clk);
		pix_valid <= 1'b0;
		while (exp_idx_q.size() > 0 && waited < 4 * PIPE_LATENCY) begin
			@(posedge clk);
			waited++;
		end
		assert (exp_idx_q.size() == 0) else begin
			$display("%0d expected results never appeared", exp_idx_q.size());
			errors++;
		end
		repeat (PIPE_LATENCY + 2) @(posedge clk);
	endtask

	task automatic check_count(input int expected);
		assert (out_count == expected) else begin
			$display("error %0t: got %0d outputs, expected %0d", $time, out_count, expected);
			errors++;
		end
	endtask

	task automatic close_test(input string name);
		int delta;
		delta = total_errors() - test_start;
		tests_run++;
		if (delta == 0) begin
			$display("test %0d %s: pass", tests_run, name);
		end else begin
			tests_failing++;
			$display("test %0d %s: FAIL with %0d errors", tests_run, name, delta);
		end
		test_start = total_errors();
	endtask

	task automatic run_flat(input pixel_t p);
		apply_reset();
		flat_pix = {flat_expect(p.r), flat_expect(p.g), flat_expect(p.b)};
		flat_check = 1'b1;
		send_flat(12 * LW, p);
		drain_outputs();
		check_count(12 * LW - WARMUP);
		flat_check = 1'b0;
	endtask

	initial begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		pix_valid = 1'b0;
		pix_in    = '0;

		// Window fills exactly on the next pixel.
		apply_reset();
		send_random(WARMUP, 1'b0);
		drain_outputs();
		check_count(0);
		send_random(1, 1'b0);
		drain_outputs();
		check_count(1);
		close_test("warm-up");

		run_flat({8'd10, 8'd20, 8'd30});
		run_flat(24'h000000);
		close_test("flat images");

		apply_reset();
		send_random(20 * LW, 1'b0);
		drain_outputs();
		check_count(20 * LW - WARMUP);
		close_test("random image");

		apply_reset();
		send_random(20 * LW, 1'b1);
		drain_outputs();
		check_count(20 * LW - WARMUP);
		close_test("input gaps");

		apply_reset();
		send_random(250, 1'b0);
		apply_reset();
		send_random(200, 1'b0);
		drain_outputs();
		check_count(200 - WARMUP);
		close_test("reset mid-stream");

		$display("summary: %0d run, %0d failing, %0d check errors, %0d assertion failures",
			tests_run, tests_failing, errors, dut0.asserts0.fail_count);
		if (total_errors() == 0 && tests_failing == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("tests failed");
		$finish;
	end

endmodule

// ==== sources.f ====
src/gauss_pkg.sv
src/gauss_line_buffer.sv
src/gauss_window.sv
src/gauss_conv.sv
src/gauss_filter_top.sv
sim/gauss_tb_asserts.sv
sim/gauss_tb.sv
